// File: logic/perceptron_pkg.sv
package perceptron_pkg;

	// signed weight width, one weight per history bit plus the bias
	localparam int WEIGHT_BITS = 8;

	// symmetric saturation, so the most negative code is never stored
	localparam int WEIGHT_MAX = 127;

	// y width: 31 weights of magnitude 127 still fit without wrapping
	localparam int Y_BITS = WEIGHT_BITS + 5;

	// default global history length
	localparam int DEFAULT_HISTORY_LEN = 12;

	// default index width, giving 256 rows
	localparam int DEFAULT_INDEX_BITS = 8;

	// floor(1.93 * 12 + 14) = 37, one step more for margin
	localparam int DEFAULT_THRESHOLD = 38;

	// controller states
	typedef enum logic [2:0] {
		// table sweep after reset
		CLEAR,
		// ready for a new branch
		IDLE,
		// table row being read
		READ,
		// prediction out, waiting for the real outcome
		WAIT_OUTCOME,
		// row write-back and history shift
		TRAIN
	} ctrl_state_t;

endpackage

// File: logic/weight_table.sv
`timescale 1ns/1ns

module weight_table
	import perceptron_pkg::*;
#(
	parameter int HISTORY_LEN = DEFAULT_HISTORY_LEN,
	parameter int INDEX_BITS = DEFAULT_INDEX_BITS
) (
	input  logic clk,
	input  logic rst,
	input  logic rd_en,
	input  logic [INDEX_BITS-1:0] rd_index,
	output logic [(HISTORY_LEN+1)*WEIGHT_BITS-1:0] rd_row,
	input  logic wr_en,
	input  logic [INDEX_BITS-1:0] wr_index,
	input  logic [(HISTORY_LEN+1)*WEIGHT_BITS-1:0] wr_row,
	output logic clear_done
);

	localparam int ROW_BITS = (HISTORY_LEN + 1) * WEIGHT_BITS;
	localparam int ROWS = 1 << INDEX_BITS;

	logic [ROW_BITS-1:0] mem [ROWS];

	// sweep state, one row cleared per cycle
	logic clearing;
	logic [INDEX_BITS-1:0] clr_cnt;
	logic last_row;

	assign last_row = &clr_cnt;

	// high in the last sweep cycle and stays high afterwards
	assign clear_done = !clearing || last_row;

	always_ff @(posedge clk) begin
		if (rst) begin
			clearing <= 1'b1;
			clr_cnt <= '0;
		end else if (clearing) begin
			clr_cnt <= clr_cnt + 1'b1;
			if (last_row) begin
				clearing <= 1'b0;
			end
		end
	end

	// single write port, the sweep has priority over training writes
	always_ff @(posedge clk) begin
		if (clearing) begin
			mem[clr_cnt] <= '0;
		end else if (wr_en) begin
			mem[wr_index] <= wr_row;
		end
	end

	// registered read, row holds until the next request
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_row <= mem[rd_index];
		end
	end

endmodule

// File: logic/dot_product.sv
`timescale 1ns/1ns

module dot_product
	import perceptron_pkg::*;
#(
	parameter int HISTORY_LEN = DEFAULT_HISTORY_LEN
) (
	input  logic clk,
	input  logic rst,
	input  logic [(HISTORY_LEN+1)*WEIGHT_BITS-1:0] row,
	input  logic [HISTORY_LEN-1:0] history,
	output logic signed [Y_BITS-1:0] y,
	output logic pred_taken
);

	logic signed [Y_BITS-1:0] sum;

	// bias sits in the top slot of the row
	always_comb begin
		logic signed [WEIGHT_BITS-1:0] w;
		w = row[HISTORY_LEN*WEIGHT_BITS +: WEIGHT_BITS];
		sum = Y_BITS'(w);
		for (int i = 0; i < HISTORY_LEN; i++) begin
			w = row[i*WEIGHT_BITS +: WEIGHT_BITS];
			// taken history bit counts as +1, not taken as -1
			if (history[i]) begin
				sum = sum + Y_BITS'(w);
			end else begin
				sum = sum - Y_BITS'(w);
			end
		end
	end

	// zero counts as taken
	always_ff @(posedge clk) begin
		if (rst) begin
			y <= '0;
			pred_taken <= 1'b1;
		end else begin
			y <= sum;
			pred_taken <= !sum[Y_BITS-1];
		end
	end

endmodule

// File: logic/weight_trainer.sv
`timescale 1ns/1ns

module weight_trainer
	import perceptron_pkg::*;
#(
	parameter int HISTORY_LEN = DEFAULT_HISTORY_LEN,
	parameter int THRESHOLD = DEFAULT_THRESHOLD
) (
	input  logic [(HISTORY_LEN+1)*WEIGHT_BITS-1:0] row,
	input  logic [HISTORY_LEN-1:0] history,
	input  logic signed [Y_BITS-1:0] y,
	input  logic predicted,
	input  logic taken,
	output logic do_train,
	output logic [(HISTORY_LEN+1)*WEIGHT_BITS-1:0] new_row
);

	logic [Y_BITS-1:0] abs_y;

	// one step up or down, held at +/-WEIGHT_MAX
	function automatic logic [WEIGHT_BITS-1:0] step_weight(
		input logic [WEIGHT_BITS-1:0] w_bits,
		input logic up
	);
		logic signed [WEIGHT_BITS-1:0] w;
		w = w_bits;
		if (up) begin
			if (w < WEIGHT_MAX) begin
				w = w + WEIGHT_BITS'(1);
			end
		end else begin
			if (w > -WEIGHT_MAX) begin
				w = w - WEIGHT_BITS'(1);
			end
		end
		return w;
	endfunction

	// y never reaches the most negative code, so the negation is safe
	assign abs_y = y[Y_BITS-1] ? Y_BITS'(-y) : Y_BITS'(y);

	assign do_train = (predicted != taken) || (abs_y <= Y_BITS'(THRESHOLD));

	always_comb begin
		for (int i = 0; i < HISTORY_LEN; i++) begin
			// agreement between history bit and outcome pulls the weight up
			new_row[i*WEIGHT_BITS +: WEIGHT_BITS] =
				step_weight(row[i*WEIGHT_BITS +: WEIGHT_BITS], history[i] == taken);
		end
		// bias follows the outcome alone
		new_row[HISTORY_LEN*WEIGHT_BITS +: WEIGHT_BITS] =
			step_weight(row[HISTORY_LEN*WEIGHT_BITS +: WEIGHT_BITS], taken);
	end

endmodule

// File: logic/predictor_ctrl.sv
`timescale 1ns/1ns

module predictor_ctrl
	import perceptron_pkg::*;
#(
	parameter int HISTORY_LEN = DEFAULT_HISTORY_LEN,
	parameter int INDEX_BITS = DEFAULT_INDEX_BITS
) (
	input  logic clk,
	input  logic rst,
	input  logic branch_valid,
	input  logic [63:0] pc,
	input  logic outcome_valid,
	input  logic outcome_taken,
	input  logic clear_done,
	input  logic [(HISTORY_LEN+1)*WEIGHT_BITS-1:0] rd_row,
	input  logic signed [Y_BITS-1:0] y,
	input  logic pred_taken,
	input  logic do_train,
	input  logic [(HISTORY_LEN+1)*WEIGHT_BITS-1:0] new_row,
	output logic ready,
	output logic prediction_valid,
	output logic prediction_taken,
	output logic rd_en,
	output logic [INDEX_BITS-1:0] rd_index,
	output logic wr_en,
	output logic [INDEX_BITS-1:0] wr_index,
	output logic [(HISTORY_LEN+1)*WEIGHT_BITS-1:0] wr_row,
	output logic [HISTORY_LEN-1:0] history,
	output logic [(HISTORY_LEN+1)*WEIGHT_BITS-1:0] saved_row,
	output logic signed [Y_BITS-1:0] saved_y,
	output logic saved_pred
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	// y and prediction are valid in the cycle after READ
	logic pred_pulse;

	logic signed [Y_BITS-1:0] y_hold;
	logic pred_hold;
	logic taken_q;
	logic resolve;

	assign resolve = (state == WAIT_OUTCOME) && outcome_valid;

	always_comb begin
		next_state = state;
		case (state)
			CLEAR: begin
				if (clear_done) begin
					next_state = IDLE;
				end
			end
			IDLE: begin
				if (branch_valid) begin
					next_state = READ;
				end
			end
			READ: next_state = WAIT_OUTCOME;
			WAIT_OUTCOME: begin
				if (outcome_valid) begin
					next_state = TRAIN;
				end
			end
			TRAIN: next_state = IDLE;
			default: next_state = CLEAR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CLEAR;
			pred_pulse <= 1'b0;
			wr_en <= 1'b0;
			history <= '0;
		end else begin
			state <= next_state;
			pred_pulse <= (state == READ);
			// write goes out in TRAIN, one cycle after the outcome
			wr_en <= resolve && do_train;
			if (state == TRAIN) begin
				history <= {history[HISTORY_LEN-2:0], taken_q};
			end
		end
	end

	// payload of the outstanding branch
	always_ff @(posedge clk) begin
		if (rd_en) begin
			wr_index <= rd_index;
		end
		if (state == READ) begin
			saved_row <= rd_row;
		end
		if (pred_pulse) begin
			y_hold <= y;
			pred_hold <= pred_taken;
		end
		if (resolve) begin
			taken_q <= outcome_taken;
			wr_row <= new_row;
		end
	end

	// an outcome may come in the same cycle as the prediction
	assign saved_y = pred_pulse ? y : y_hold;
	assign saved_pred = pred_pulse ? pred_taken : pred_hold;

	assign ready = (state == IDLE);
	assign rd_en = (state == IDLE) && branch_valid;
	assign rd_index = pc[INDEX_BITS-1:0];

	assign prediction_valid = pred_pulse;
	assign prediction_taken = pred_taken;

endmodule

// File: logic/perceptron_predictor.sv
`timescale 1ns/1ns

module perceptron_predictor
	import perceptron_pkg::*;
#(
	parameter int HISTORY_LEN = DEFAULT_HISTORY_LEN,
	parameter int INDEX_BITS = DEFAULT_INDEX_BITS,
	parameter int THRESHOLD = DEFAULT_THRESHOLD
) (
	input  logic clk,
	input  logic rst,
	input  logic branch_valid,
	input  logic [63:0] pc,
	input  logic outcome_valid,
	input  logic outcome_taken,
	output logic ready,
	output logic prediction_valid,
	output logic prediction_taken
);

	localparam int ROW_BITS = (HISTORY_LEN + 1) * WEIGHT_BITS;

	// table ports
	logic rd_en;
	logic [INDEX_BITS-1:0] rd_index;
	logic [ROW_BITS-1:0] rd_row;
	logic wr_en;
	logic [INDEX_BITS-1:0] wr_index;
	logic [ROW_BITS-1:0] wr_row;
	logic clear_done;

	// prediction and training path
	logic [HISTORY_LEN-1:0] history;
	logic signed [Y_BITS-1:0] y;
	logic pred_taken;
	logic [ROW_BITS-1:0] saved_row;
	logic signed [Y_BITS-1:0] saved_y;
	logic saved_pred;
	logic do_train;
	logic [ROW_BITS-1:0] new_row;

	weight_table #(
		.HISTORY_LEN(HISTORY_LEN),
		.INDEX_BITS(INDEX_BITS)
	) weight_table_i (
		.clk(clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.rd_row(rd_row),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_row(wr_row),
		.clear_done(clear_done)
	);

	dot_product #(
		.HISTORY_LEN(HISTORY_LEN)
	) dot_product_i (
		.clk(clk),
		.rst(rst),
		.row(rd_row),
		.history(history),
		.y(y),
		.pred_taken(pred_taken)
	);

	// the outcome is only looked at while it is strobed
	weight_trainer #(
		.HISTORY_LEN(HISTORY_LEN),
		.THRESHOLD(THRESHOLD)
	) weight_trainer_i (
		.row(saved_row),
		.history(history),
		.y(saved_y),
		.predicted(saved_pred),
		.taken(outcome_taken),
		.do_train(do_train),
		.new_row(new_row)
	);

	predictor_ctrl #(
		.HISTORY_LEN(HISTORY_LEN),
		.INDEX_BITS(INDEX_BITS)
	) predictor_ctrl_i (
		.clk(clk),
		.rst(rst),
		.branch_valid(branch_valid),
		.pc(pc),
		.outcome_valid(outcome_valid),
		.outcome_taken(outcome_taken),
		.clear_done(clear_done),
		.rd_row(rd_row),
		.y(y),
		.pred_taken(pred_taken),
		.do_train(do_train),
		.new_row(new_row),
		.ready(ready),
		.prediction_valid(prediction_valid),
		.prediction_taken(prediction_taken),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_row(wr_row),
		.history(history),
		.saved_row(saved_row),
		.saved_y(saved_y),
		.saved_pred(saved_pred)
	);

endmodule

// File: testbench/perceptron_predictor_props.sv
`timescale 1ns/1ns

module perceptron_predictor_props
	import perceptron_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic branch_valid,
	input  logic outcome_valid,
	input  logic ready,
	input  logic prediction_valid,
	input  logic clearing,
	input  ctrl_state_t state
);

	// a branch was accepted and its outcome has not come yet
	logic outstanding;

	always_ff @(posedge clk) begin
		if (rst) begin
			outstanding <= 1'b0;
		end else if (branch_valid && ready) begin
			outstanding <= 1'b1;
		end else if (outcome_valid) begin
			outstanding <= 1'b0;
		end
	end

	// an accepted branch gives a prediction pulse two cycles later
	assert property (@(posedge clk) disable iff (rst)
		(branch_valid && ready) |-> ##2 prediction_valid)
		else $error("prediction_valid missing two cycles after an accepted branch");

	// and no prediction pulse comes without one
	assert property (@(posedge clk) disable iff (rst)
		prediction_valid |-> $past(branch_valid && ready, 2))
		else $error("prediction_valid without an accepted branch");

	// one branch in flight at most
	assert property (@(posedge clk) disable iff (rst)
		outstanding |-> !ready)
		else $error("ready high while a branch is outstanding");

	assert property (@(posedge clk) disable iff (rst)
		clearing |-> !ready)
		else $error("ready high during the table clear");

	assert property (@(posedge clk) disable iff (rst)
		outcome_valid |-> (state == WAIT_OUTCOME))
		else $error("outcome_valid outside WAIT_OUTCOME");

endmodule

bind perceptron_predictor perceptron_predictor_props props_i (
	.clk(clk),
	.rst(rst),
	.branch_valid(branch_valid),
	.outcome_valid(outcome_valid),
	.ready(ready),
	.prediction_valid(prediction_valid),
	.clearing(weight_table_i.clearing),
	.state(predictor_ctrl_i.state)
);

// File: testbench/perceptron_predictor_tb.sv
`timescale 1ns/1ns

module perceptron_predictor_tb
	import perceptron_pkg::*;
();

	localparam int HISTORY_LEN = DEFAULT_HISTORY_LEN;
	localparam int INDEX_BITS = DEFAULT_INDEX_BITS;
	localparam int THRESHOLD = DEFAULT_THRESHOLD;
	localparam int MAX_CASES = 64;

	logic clk;
	logic rst;
	logic branch_valid;
	logic [63:0] pc;
	logic outcome_valid;
	logic outcome_taken;
	logic ready;
	logic prediction_valid;
	logic prediction_taken;

	// case table, one entry per line of the case file
	logic [63:0] case_pc [MAX_CASES];
	int case_taken [MAX_CASES];
	int case_delay [MAX_CASES];
	int case_early [MAX_CASES];
	int case_expect [MAX_CASES];
	int n_cases;
	int max_delay;

	int errors;
	int checks;
	int pulses;
	int cycles;
	int limit;
	int clear_cycles;

	perceptron_predictor #(
		.HISTORY_LEN(HISTORY_LEN),
		.INDEX_BITS(INDEX_BITS),
		.THRESHOLD(THRESHOLD)
	) perceptron_predictor_i (
		.clk(clk),
		.rst(rst),
		.branch_valid(branch_valid),
		.pc(pc),
		.outcome_valid(outcome_valid),
		.outcome_taken(outcome_taken),
		.ready(ready),
		.prediction_valid(prediction_valid),
		.prediction_taken(prediction_taken)
	);

	always #2 clk = ~clk;

	// prediction pulses, compared with the case count at the end
	always @(posedge clk) begin
		if (!rst && prediction_valid) begin
			pulses++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic read_cases();
		int fd;
		int code;
		string line;
		logic [63:0] addr;
		int t;
		int d;
		int e;
		int p;
		fd = $fopen("testbench/predictor_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the case file");
			return;
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			// comment lines start with a hash
			if (code > 0 && line.len() > 0 && line[0] != "#") begin
				if ($sscanf(line, "%h %d %d %d %d", addr, t, d, e, p) == 5
						&& n_cases < MAX_CASES) begin
					case_pc[n_cases] = addr;
					case_taken[n_cases] = t;
					case_delay[n_cases] = d;
					case_early[n_cases] = e;
					case_expect[n_cases] = p;
					if (d > max_delay) begin
						max_delay = d;
					end
					n_cases++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic run_case(input int idx);
		string name;
		name = $sformatf("case %0d pc %0h", idx + 1, case_pc[idx]);
		while (!ready) begin
			@(negedge clk);
		end
		pc = case_pc[idx];
		branch_valid = 1'b1;
		@(negedge clk);
		// extra strobe while busy must be dropped
		branch_valid = (case_early[idx] != 0);
		@(negedge clk);
		branch_valid = 1'b0;
		while (!prediction_valid) begin
			@(negedge clk);
		end
		check_value(name, case_expect[idx], int'(prediction_taken));
		repeat (case_delay[idx]) @(negedge clk);
		outcome_taken = (case_taken[idx] != 0);
		outcome_valid = 1'b1;
		@(negedge clk);
		outcome_valid = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		branch_valid = 1'b0;
		pc = '0;
		outcome_valid = 1'b0;
		outcome_taken = 1'b0;
		errors = 0;
		checks = 0;
		pulses = 0;
		cycles = 0;
		limit = 0;
		n_cases = 0;
		max_delay = 0;
		read_cases();
		limit = (1 << INDEX_BITS) + 10 + n_cases * (max_delay + 6) + 100;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		clear_cycles = 0;
		while (!ready) begin
			@(negedge clk);
			clear_cycles++;
		end
		check_value("clear sweep cycles", 1 << INDEX_BITS, clear_cycles);
		for (int i = 0; i < n_cases; i++) begin
			run_case(i);
		end
		repeat (4) @(negedge clk);
		check_value("prediction count", n_cases, pulses);
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: testbench/predictor_cases.txt
# pc(hex) outcome(1=taken) outcome_delay early_strobe expected_prediction
0010 0 1 0 1
0010 0 0 0 0
0010 0 2 1 0
0010 0 3 0 0
0020 1 0 0 1
0020 0 1 0 1
0020 1 2 1 1
0020 0 0 0 1
0020 1 3 0 1
0020 0 1 0 0
0020 1 0 0 1
1020 0 2 1 0
0030 1 1 0 1
0030 1 0 0 0
0030 1 2 0 1
0030 1 3 0 0
0030 1 0 0 1
0030 1 1 0 1
0030 1 2 0 1
0030 1 0 1 1
0030 1 3 0 1
0030 1 1 0 1
0030 0 0 0 1
0030 1 2 0 1

// File: filelist.f
logic/perceptron_pkg.sv
logic/weight_table.sv
logic/dot_product.sv
logic/weight_trainer.sv
logic/predictor_ctrl.sv
logic/perceptron_predictor.sv
testbench/perceptron_predictor_props.sv
testbench/perceptron_predictor_tb.sv

// File: Makefile
# Verilator flow for the perceptron branch predictor

VERILATOR ?= verilator
TOP ?= perceptron_predictor_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
PASS_TEXT ?= Test passed
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
